// ==== compile.f ====
+incdir+rtl
rtl/tlb_pkg.sv
rtl/tlb_array.sv
rtl/tlb_lookup.sv
rtl/tlb_mgmt.sv
rtl/tlb_top.sv
tests/tlb_checker.sv
tests/tb_tlb.sv

// ==== rtl/tlb_array.sv ====
`include "tlb_defs.svh"

module tlb_array (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    we,
    input  logic [`TLB_IDX_W-1:0]   w_index,
    input  tlb_pkg::tlb_entry_t     w_entry,
    input  tlb_pkg::tlb_inv_t       inv,
    input  logic [`TLB_IDX_W-1:0]   r_index,
    output tlb_pkg::tlb_entry_t     r_entry,
    output tlb_pkg::tlb_entry_vec_t entries
);
    import tlb_pkg::*;

    tlb_entry_t         mem [`TLB_NUM]; // payload fields, e lives in e_q
    logic [`TLB_NUM-1:0] e_q;
    logic [`TLB_NUM-1:0] inv_clr;       // per-entry invalidate hit

    // whole-entry write, no reset on the payload
    always_ff @(posedge clk) begin
        if (we) begin
            mem[w_index] <= w_entry;
        end
    end

    // invalidate decode per entry
    always_comb begin
        logic asid_eq;
        logic vhit;
        for (int i = 0; i < `TLB_NUM; i++) begin
            asid_eq = (mem[i].asid == inv.asid);
            vhit    = tlb_vppn_hit(mem[i], inv.vppn);
            case (inv.op)
                5'd0, 5'd1: inv_clr[i] = 1'b1;                       // everything
                5'd2:       inv_clr[i] = mem[i].g;                   // global only
                5'd3:       inv_clr[i] = !mem[i].g;                  // non-global only
                5'd4:       inv_clr[i] = !mem[i].g && asid_eq;
                5'd5:       inv_clr[i] = !mem[i].g && asid_eq && vhit;
                5'd6:       inv_clr[i] = (mem[i].g || asid_eq) && vhit;
                default:    inv_clr[i] = 1'b0;
            endcase
        end
    end

    // exists bits, the only reset state in the table
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            e_q <= '0;
        end else begin
            for (int i = 0; i < `TLB_NUM; i++) begin
                if (we && (w_index == `TLB_IDX_W'(i))) begin
                    e_q[i] <= w_entry.e;
                end else if (inv.en && inv_clr[i]) begin
                    e_q[i] <= 1'b0;
                end
            end
        end
    end

    // export the table with e taken from the reset flops
    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            entries[i]   = mem[i];
            entries[i].e = e_q[i];
        end
    end

    assign r_entry = entries[r_index]; // combinational read

endmodule

// ==== rtl/tlb_defs.svh ====
`ifndef TLB_DEFS_SVH
`define TLB_DEFS_SVH

// table geometry
`define TLB_NUM   16
`define TLB_IDX_W 4

// page size codes, log2 of the page size in bytes
`define TLB_PS_4K 6'd12
`define TLB_PS_4M 6'd22

`endif

// ==== rtl/tlb_lookup.sv ====
`include "tlb_defs.svh"

module tlb_lookup (
    input  logic                    clk,
    input  logic                    arst_n,
    input  tlb_pkg::tlb_lookup_req_t req,
    input  tlb_pkg::tlb_entry_vec_t  entries,
    output tlb_pkg::tlb_lookup_rsp_t rsp
);
    import tlb_pkg::*;

    logic                  valid_q;
    tlb_lookup_req_t       req_q;   // payload only, valid_q carries the valid bit
    logic [`TLB_NUM-1:0]   match;
    logic [`TLB_IDX_W-1:0] hit_idx;
    tlb_entry_t            hit_ent;
    logic                  odd_sel;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            req_q <= req;
        end
    end

    // compare against every entry
    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            match[i] = entries[i].e
                    && tlb_vppn_hit(entries[i], req_q.vppn)
                    && ((entries[i].asid == req_q.asid) || entries[i].g);
        end
    end

    // lowest index wins, so scan downwards and let the last hit stick
    always_comb begin
        hit_idx = '0;
        for (int i = `TLB_NUM - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = `TLB_IDX_W'(i);
            end
        end
    end

    assign hit_ent = entries[hit_idx];
    assign odd_sel = (hit_ent.ps == `TLB_PS_4K) ? req_q.odd_page : req_q.vppn[8];

    always_comb begin
        rsp       = '0;
        rsp.valid = valid_q;
        rsp.found = |match;
        if (rsp.found) begin
            rsp.index = hit_idx;
            rsp.ps    = hit_ent.ps;
            rsp.page  = odd_sel ? hit_ent.page1 : hit_ent.page0;
        end
    end

endmodule

// ==== rtl/tlb_mgmt.sv ====
`include "tlb_defs.svh"

module tlb_mgmt (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  mgmt_req,
    input  tlb_pkg::tlb_cmd_t     cmd,
    output logic                  mgmt_ack,
    output tlb_pkg::tlb_entry_t   rd_entry,
    output logic                  we,
    output logic [`TLB_IDX_W-1:0] w_index,
    output tlb_pkg::tlb_entry_t   w_entry,
    output tlb_pkg::tlb_inv_t     inv,
    output logic [`TLB_IDX_W-1:0] r_index,
    input  tlb_pkg::tlb_entry_t   r_entry
);
    import tlb_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_ACK
    } state_e;

    state_e   state_q;
    tlb_cmd_t cmd_q;   // command held for the issue cycle
    logic     issue;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE:  if (mgmt_req) state_q <= ST_ISSUE;
                ST_ISSUE: state_q <= ST_ACK;
                ST_ACK:   if (!mgmt_req) state_q <= ST_IDLE; // wait for req to drop
                default:  state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && mgmt_req) begin
            cmd_q <= cmd;
        end
    end

    assign issue = (state_q == ST_ISSUE);

    // one strobe per command
    assign we       = issue && (cmd_q.kind == cmd_write);
    assign w_index  = cmd_q.index;
    assign w_entry  = cmd_q.entry;
    assign r_index  = cmd_q.index;
    assign inv.en   = issue && (cmd_q.kind == cmd_inv);
    assign inv.op   = cmd_q.inv_op;
    assign inv.asid = cmd_q.inv_asid;
    assign inv.vppn = cmd_q.inv_vppn;

    always_ff @(posedge clk) begin
        if (issue && (cmd_q.kind == cmd_read)) begin
            rd_entry <= r_entry;
        end
    end

    assign mgmt_ack = (state_q == ST_ACK);

endmodule

// ==== rtl/tlb_pkg.sv ====
`include "tlb_defs.svh"

package tlb_pkg;

    // one half of a double page
    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        logic [18:0] vppn;
        logic [9:0]  asid;
        logic        g;
        logic [5:0]  ps;
        logic        e;     // entry exists
        tlb_page_t   page0; // even page
        tlb_page_t   page1; // odd page
    } tlb_entry_t;

    typedef tlb_entry_t [`TLB_NUM-1:0] tlb_entry_vec_t;

    typedef struct packed {
        logic        valid;
        logic [18:0] vppn;
        logic        odd_page;
        logic [9:0]  asid;
    } tlb_lookup_req_t;

    typedef struct packed {
        logic                  valid;
        logic                  found;
        logic [`TLB_IDX_W-1:0] index;
        logic [5:0]            ps;
        tlb_page_t             page;
    } tlb_lookup_rsp_t;

    typedef enum logic [1:0] {
        cmd_write,
        cmd_read,
        cmd_inv
    } tlb_cmd_kind_e;

    typedef struct packed {
        tlb_cmd_kind_e         kind;
        logic [`TLB_IDX_W-1:0] index;
        logic [4:0]            inv_op;
        logic [9:0]            inv_asid;
        logic [18:0]           inv_vppn;
        tlb_entry_t            entry;
    } tlb_cmd_t;

    typedef struct packed {
        logic        en;
        logic [4:0]  op;
        logic [9:0]  asid;
        logic [18:0] vppn;
    } tlb_inv_t;

    // 4K pages compare the full vppn, 4M pages only the upper ten bits
    function automatic logic tlb_vppn_hit(tlb_entry_t ent, logic [18:0] vppn);
        if (ent.ps == `TLB_PS_4K) begin
            return ent.vppn == vppn;
        end
        return ent.vppn[18:9] == vppn[18:9];
    endfunction

endpackage

// ==== rtl/tlb_top.sv ====
`include "tlb_defs.svh"

module tlb_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  tlb_pkg::tlb_lookup_req_t fetch_req,
    output tlb_pkg::tlb_lookup_rsp_t fetch_rsp,
    input  tlb_pkg::tlb_lookup_req_t data_req,
    output tlb_pkg::tlb_lookup_rsp_t data_rsp,
    input  logic                     mgmt_req,
    input  tlb_pkg::tlb_cmd_t        cmd,
    output logic                     mgmt_ack,
    output tlb_pkg::tlb_entry_t      rd_entry
);
    import tlb_pkg::*;

    tlb_entry_vec_t        entries;
    logic                  we;
    logic [`TLB_IDX_W-1:0] w_index;
    tlb_entry_t            w_entry;
    tlb_inv_t              inv;
    logic [`TLB_IDX_W-1:0] r_index;
    tlb_entry_t            r_entry;

    tlb_mgmt u_mgmt (
        .clk      (clk),
        .arst_n   (arst_n),
        .mgmt_req (mgmt_req),
        .cmd      (cmd),
        .mgmt_ack (mgmt_ack),
        .rd_entry (rd_entry),
        .we       (we),
        .w_index  (w_index),
        .w_entry  (w_entry),
        .inv      (inv),
        .r_index  (r_index),
        .r_entry  (r_entry)
    );

    tlb_array u_array (
        .clk     (clk),
        .arst_n  (arst_n),
        .we      (we),
        .w_index (w_index),
        .w_entry (w_entry),
        .inv     (inv),
        .r_index (r_index),
        .r_entry (r_entry),
        .entries (entries)
    );

    // instruction fetch port
    tlb_lookup u_fetch (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (fetch_req),
        .entries (entries),
        .rsp     (fetch_rsp)
    );

    // data access port
    tlb_lookup u_data (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (data_req),
        .entries (entries),
        .rsp     (data_rsp)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the TLB testbench with Verilator, run it, and grep the log for failure

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -j 0 --timescale 1ns/1ns --top-module tb_tlb \
    -f compile.f -o tb_tlb > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_tlb > sim.log 2>&1 || { echo "simulator returned an error"; }
cat sim.log

grep -q "SIMULATION FAILED" sim.log && { echo "test failed"; exit 1; } \
    || { echo "test done"; exit 0; }

// ==== tests/tb_tlb.sv ====
`include "tlb_defs.svh"

module tb_tlb;
    timeunit 1ns;
    timeprecision 1ns;
    import tlb_pkg::*;

    localparam int NUM_RAND_LOOKUPS = 200;
    localparam int NUM_INV_OPS      = 8;   // op 7 must leave the table alone
    localparam int NUM_CMDS         = 2 * `TLB_NUM + NUM_INV_OPS * (2 * `TLB_NUM + 1);
    localparam int NUM_LOOKUPS      = NUM_RAND_LOOKUPS + NUM_INV_OPS * `TLB_NUM;
    localparam int WATCHDOG_CYCLES  = NUM_CMDS * 10 + NUM_LOOKUPS * 2 + 64;

    logic            clk, arst_n, mgmt_req, mgmt_ack;
    tlb_lookup_req_t fetch_req, data_req;
    tlb_lookup_rsp_t fetch_rsp, data_rsp;
    tlb_cmd_t        cmd;
    tlb_entry_t      rd_entry;
    tlb_entry_t      shadow [`TLB_NUM]; // last entry written per index for building lookups
    logic [31:0]     lfsr_q;
    int              tb_errors, chk_errors, chk_checks;

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rnd(int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // vppn bits 12:9 carry the index so no two entries overlap
    function automatic tlb_entry_t random_entry(int idx);
        tlb_entry_t e;
        e.vppn       = 19'(rnd(19));
        e.vppn[12:9] = 4'(idx);
        e.asid       = 10'h0a0 + 10'(rnd(2)); // small pool so asids repeat
        e.g          = (rnd(2) == 0);
        e.ps         = (rnd(1) == 1) ? `TLB_PS_4M : `TLB_PS_4K;
        e.e          = (rnd(3) != 0);
        e.page0      = 26'(rnd(26));
        e.page1      = 26'(rnd(26));
        return e;
    endfunction

    function automatic tlb_lookup_req_t make_req(int idx, int mode);
        tlb_lookup_req_t r;
        r.valid    = 1'b1;
        r.vppn     = shadow[idx].vppn;
        r.asid     = shadow[idx].asid;
        r.odd_page = 1'(rnd(1));
        if (shadow[idx].ps == `TLB_PS_4M) r.vppn[8:0] = 9'(rnd(9));
        if (mode == 0) r.asid = 10'(rnd(10)); // hits only a global entry
        if (mode == 1) r.vppn = 19'(rnd(19)); // mostly a miss
        return r;
    endfunction

    task automatic mgmt_cmd(tlb_cmd_t c);
        int waited;
        @(posedge clk);
        mgmt_req <= 1'b1;
        cmd      <= c;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!mgmt_ack && waited < 20);
        if (!mgmt_ack) begin
            tb_errors++;
            $display("no mgmt_ack within 20 cycles for command at index %0d", c.index);
        end
        mgmt_req <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (mgmt_ack && waited < 20);
        if (mgmt_ack) begin
            tb_errors++;
            $display("mgmt_ack still high 20 cycles after mgmt_req fell");
        end
    endtask

    task automatic issue(tlb_cmd_kind_e kind, int idx, tlb_entry_t e, int op,
                         logic [9:0] asid, logic [18:0] vppn);
        tlb_cmd_t c;
        c          = '0;
        c.kind     = kind;
        c.index    = 4'(idx);
        c.entry    = e;
        c.inv_op   = 5'(op);
        c.inv_asid = asid;
        c.inv_vppn = vppn;
        mgmt_cmd(c);
    endtask

    task automatic refill_table();
        for (int i = 0; i < `TLB_NUM; i++) begin
            shadow[i] = random_entry(i);
            issue(cmd_write, i, shadow[i], 0, '0, '0);
        end
    endtask

    task automatic read_all();
        for (int i = 0; i < `TLB_NUM; i++) issue(cmd_read, i, '0, 0, '0, '0);
    endtask

    // drives both ports every cycle and a sweep walks all indices with exact requests
    task automatic run_lookups(int n, bit sweep);
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            if (sweep) begin
                fetch_req <= make_req(k % `TLB_NUM, 2);
                data_req  <= make_req((k + 8) % `TLB_NUM, 2);
            end else begin
                fetch_req <= make_req(int'(rnd(4)), int'(rnd(2)));
                data_req  <= make_req(int'(rnd(4)), int'(rnd(2)));
            end
        end
        @(posedge clk);
        fetch_req.valid <= 1'b0;
        data_req.valid  <= 1'b0;
    endtask

    tlb_top tlb_top_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .data_req  (data_req),
        .data_rsp  (data_rsp),
        .mgmt_req  (mgmt_req),
        .cmd       (cmd),
        .mgmt_ack  (mgmt_ack),
        .rd_entry  (rd_entry)
    );

    tlb_checker u_checker (
        .clk       (clk),
        .arst_n    (arst_n),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .data_req  (data_req),
        .data_rsp  (data_rsp),
        .mgmt_req  (mgmt_req),
        .cmd       (cmd),
        .mgmt_ack  (mgmt_ack),
        .rd_entry  (rd_entry),
        .errors    (chk_errors),
        .checks    (chk_checks)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int              j;
        tlb_lookup_req_t inv_req;
        lfsr_q    = 32'h4b59_c345;
        arst_n    = 1'b0;
        mgmt_req  = 1'b0;
        cmd       = '0;
        fetch_req = '0;
        data_req  = '0;
        tb_errors = 0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;

        refill_table(); // write then read back every index
        read_all();
        run_lookups(NUM_RAND_LOOKUPS, 1'b0);

        for (int op = 0; op < NUM_INV_OPS; op++) begin
            refill_table();
            j       = int'(rnd(4));
            inv_req = make_req(j, 2); // vppn and asid that fall inside entry j
            issue(cmd_inv, 0, '0, op, inv_req.asid, inv_req.vppn);
            read_all();
            run_lookups(`TLB_NUM, 1'b1);
        end
        repeat (4) @(posedge clk);

        $display("checks: %0d, checker errors: %0d, testbench errors: %0d",
                 chk_checks, chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/tlb_checker.sv ====
`include "tlb_defs.svh"

module tlb_checker (
    input  logic                     clk,
    input  logic                     arst_n,
    input  tlb_pkg::tlb_lookup_req_t fetch_req,
    input  tlb_pkg::tlb_lookup_rsp_t fetch_rsp,
    input  tlb_pkg::tlb_lookup_req_t data_req,
    input  tlb_pkg::tlb_lookup_rsp_t data_rsp,
    input  logic                     mgmt_req,
    input  tlb_pkg::tlb_cmd_t        cmd,
    input  logic                     mgmt_ack,
    input  tlb_pkg::tlb_entry_t      rd_entry,
    output int                       errors,
    output int                       checks
);
    timeunit 1ns;
    timeprecision 1ns;
    import tlb_pkg::*;

    tlb_entry_t      model [`TLB_NUM]; // reference copy of the table
    tlb_cmd_t        cur;              // command in flight
    logic            busy, ack_seen, prev_ack, prev_req;
    int              phase;            // edges since the request was first seen
    logic            fetch_pv, data_pv;
    tlb_lookup_req_t fetch_pr, data_pr;

    function automatic logic covers(tlb_entry_t ent, logic [18:0] vppn);
        logic [18:0] care;
        // a 4M page spans 512 small pages
        care = (ent.ps == `TLB_PS_4K) ? 19'h7_ffff : 19'h7_fe00;
        return ((ent.vppn ^ vppn) & care) == 19'h0;
    endfunction

    function automatic tlb_lookup_rsp_t expect_lookup(tlb_lookup_req_t r);
        tlb_lookup_rsp_t x;
        logic            odd;
        x = '0;
        x.valid = 1'b1;
        for (int i = 0; i < `TLB_NUM; i++) begin
            if (!x.found && model[i].e && covers(model[i], r.vppn)
                    && (model[i].g || model[i].asid == r.asid)) begin
                x.found = 1'b1;
                x.index = 4'(i);
                x.ps    = model[i].ps;
                odd     = (model[i].ps == `TLB_PS_4K) ? r.odd_page : r.vppn[8];
                x.page  = odd ? model[i].page1 : model[i].page0;
            end
        end
        return x;
    endfunction

    task automatic mismatch(string sig, logic [127:0] exp_v, logic [127:0] act_v);
        errors++;
        $display("** Error at %0t ns: %s expected %0h, got %0h", $time, sig, exp_v, act_v);
    endtask

    task automatic fault(string msg);
        errors++;
        $display("handshake fault at %0t ns: %s", $time, msg);
    endtask

    task automatic check_lookup(string sig, logic pend_v, tlb_lookup_req_t pend_r,
                                tlb_lookup_rsp_t rsp);
        tlb_lookup_rsp_t exp_rsp;
        checks++;
        if (!pend_v) begin
            if (rsp.valid !== 1'b0) mismatch({sig, ".valid"}, 128'(0), 128'(rsp.valid));
        end else begin
            exp_rsp = expect_lookup(pend_r);
            if (rsp !== exp_rsp) mismatch(sig, 128'(exp_rsp), 128'(rsp));
        end
    endtask

    task automatic apply_cmd(tlb_cmd_t c);
        logic asid_eq;
        logic vhit;
        if (c.kind == cmd_write) begin
            model[c.index] = c.entry;
        end else if (c.kind == cmd_inv) begin
            for (int i = 0; i < `TLB_NUM; i++) begin
                asid_eq = (model[i].asid == c.inv_asid);
                vhit    = covers(model[i], c.inv_vppn);
                case (c.inv_op)
                    5'd0, 5'd1: model[i].e = 1'b0;
                    5'd2: if (model[i].g) model[i].e = 1'b0;
                    5'd3: if (!model[i].g) model[i].e = 1'b0;
                    5'd4: if (!model[i].g && asid_eq) model[i].e = 1'b0;
                    5'd5: if (!model[i].g && asid_eq && vhit) model[i].e = 1'b0;
                    5'd6: if ((model[i].g || asid_eq) && vhit) model[i].e = 1'b0;
                    default: ; // unknown op leaves the table alone
                endcase
            end
        end
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `TLB_NUM; i++) model[i].e = 1'b0;
            busy     = 1'b0;
            ack_seen = 1'b0;
            prev_ack = 1'b0;
            prev_req = 1'b0;
            phase    = 0;
            fetch_pv = 1'b0;
            data_pv  = 1'b0;
            errors   = 0;
            checks   = 0;
        end else begin
            check_lookup("fetch_rsp", fetch_pv, fetch_pr, fetch_rsp);
            check_lookup("data_rsp", data_pv, data_pr, data_rsp);
            fetch_pv = fetch_req.valid;
            fetch_pr = fetch_req;
            data_pv  = data_req.valid;
            data_pr  = data_req;
            if (busy) begin
                phase++;
                if (phase == 1) begin
                    if (mgmt_ack !== 1'b0) begin
                        fault("mgmt_ack rose before the command reached the table");
                    end
                    apply_cmd(cur); // array takes the strobe on this edge
                end
                if (phase == 2) begin
                    checks++;
                    if (mgmt_ack !== 1'b1) begin
                        fault("mgmt_ack did not rise one cycle after the command was issued");
                    end else if (cur.kind == cmd_read && rd_entry !== model[cur.index]) begin
                        mismatch("rd_entry", 128'(model[cur.index]), 128'(rd_entry));
                    end
                end
                if (!ack_seen && !mgmt_req) fault("mgmt_req fell before mgmt_ack was seen");
                if (prev_ack && mgmt_ack && !prev_req) begin
                    fault("mgmt_ack stayed high after mgmt_req fell");
                end
                if (prev_ack && !mgmt_ack) begin
                    if (prev_req) fault("mgmt_ack fell while mgmt_req was still high");
                    busy = 1'b0;
                end
                if (mgmt_ack) ack_seen = 1'b1;
            end else begin
                if (mgmt_ack) fault("mgmt_ack high with no request outstanding");
                if (mgmt_req) begin
                    busy     = 1'b1;
                    ack_seen = 1'b0;
                    phase    = 0;
                    cur      = cmd;
                end
            end
            prev_ack = mgmt_ack;
            prev_req = mgmt_req;
        end
    end

endmodule
